// File: design/csr_defs.svh
// machine CSR addresses, interrupt cause codes and live bit masks
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// trap setup and handling
`define CSR_MSTATUS     12'h300
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MIP         12'h344

// machine counters, low and high halves
`define CSR_MCYCLE      12'hB00
`define CSR_MCYCLEH     12'hB80
`define CSR_MINSTRET    12'hB02
`define CSR_MINSTRETH   12'hB82

// read-only information registers
`define CSR_MHARTID     12'hF14
`define CSR_MCONFIGPTR  12'hF15

// interrupt cause codes, same as the bit positions in mie and mip
`define IRQ_CODE_MSI    4'd3
`define IRQ_CODE_MTI    4'd7
`define IRQ_CODE_MEI    4'd11

// writable bits of mstatus (mpie, mie) and of mie (meie, mtie, msie)
`define MSTATUS_LIVE_MASK 32'h0000_0088
`define MIE_LIVE_MASK     32'h0000_0888

// single hart, no configuration structure
`define HART_ID_VALUE     32'h0000_0000
`define CONFIGPTR_VALUE   32'h0000_0000

`endif

// File: design/trap_pkg.sv
// trap_pkg: CSR word structs, exception request, trap commit and redirect types
`default_nettype none

package trap_pkg;

  // machine status word, only mpie and mie are implemented
  typedef struct packed {
    logic [23:0] rsvd_hi;
    logic        mpie;
    logic [2:0]  rsvd_mid;
    logic        mie;
    logic [2:0]  rsvd_lo;
  } mstatus_t;

  // interrupt enable word
  typedef struct packed {
    logic [19:0] rsvd_hi;
    logic        meie;
    logic [2:0]  rsvd_b;
    logic        mtie;
    logic [2:0]  rsvd_a;
    logic        msie;
    logic [2:0]  rsvd_lo;
  } mie_t;

  // interrupt pending word, same layout as mie
  typedef struct packed {
    logic [19:0] rsvd_hi;
    logic        meie;
    logic [2:0]  rsvd_b;
    logic        mtie;
    logic [2:0]  rsvd_a;
    logic        msie;
    logic [2:0]  rsvd_lo;
  } mip_t;

  // synchronous exception raised by the pipeline
  typedef struct packed {
    logic [3:0]  cause;
    logic [31:0] pc;
    logic [31:0] tval;
  } exc_req_t;

  // trap update for the CSR file, cause is the mcause code field
  typedef struct packed {
    logic        take;
    logic        intr;
    logic [30:0] cause;
    logic [31:0] epc;
    logic [31:0] tval;
  } trap_commit_t;

  // new fetch target for the core
  typedef struct packed {
    logic [31:0] pc;
    logic        is_mret;
  } redirect_t;

endpackage

`default_nettype wire

// File: design/handshake_slice.sv
// handshake_slice: one-entry registered valid/ready slice for any payload type
`timescale 1ns/1ps
`default_nettype none

module handshake_slice #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_sync,

  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,

  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full_q;
  payload_t data_q;
  logic     load;

  // accept when empty, or when the held entry leaves this cycle
  assign in_ready = !full_q || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst_sync) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (out_ready) begin
      full_q <= 1'b0;
    end
  end

  // payload register
  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full_q;
  assign out_data  = data_q;

  // a stalled entry keeps its payload and stays valid
  out_hold_a : assert property (
    @(posedge clk) disable iff (rst_sync)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else $error("handshake_slice: output changed while stalled");

endmodule

`default_nettype wire

// File: design/csr_file.sv
// csr_file: machine CSR storage, 64-bit counters, software port and trap updates
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

module csr_file (
  input  logic                   clk,
  input  logic                   rst_sync,
  input  logic                   instruction_retire,

  input  logic                   csr_r_en,
  input  logic                   csr_w_en,
  input  logic [11:0]            csr_addr,
  input  logic [31:0]            csr_wdata,
  output logic [31:0]            csr_rdata,

  input  trap_pkg::trap_commit_t commit,
  input  logic                   mret_take,

  output trap_pkg::mstatus_t     mstatus,
  output trap_pkg::mie_t         mie,
  output trap_pkg::mip_t         mip,
  output logic [31:0]            mtvec,
  output logic [31:0]            mepc,

  input  logic                   mext_int,
  input  logic                   msw_int,
  input  logic                   mtimer_int
);

  logic [31:0] mscratch;
  logic [31:0] mcause;
  logic [31:0] mtval;
  logic [31:0] mcycle;
  logic [31:0] mcycleh;
  logic [31:0] minstret;
  logic [31:0] minstreth;
  logic [32:0] mcycle_inc;
  logic [32:0] minstret_inc;

  // pending bits follow the interrupt lines directly
  always_comb begin
    mip      = '0;
    mip.meie = mext_int;
    mip.mtie = mtimer_int;
    mip.msie = msw_int;
  end

  // carry out of the low half feeds the high half
  assign mcycle_inc   = {1'b0, mcycle} + 33'd1;
  assign minstret_inc = {1'b0, minstret} + {32'd0, instruction_retire};

  always_ff @(posedge clk) begin
    if (rst_sync) begin
      mcycle    <= '0;
      mcycleh   <= '0;
      minstret  <= '0;
      minstreth <= '0;
    end else begin
      mcycle    <= (csr_w_en && csr_addr == `CSR_MCYCLE) ? csr_wdata : mcycle_inc[31:0];
      mcycleh   <= (csr_w_en && csr_addr == `CSR_MCYCLEH) ? csr_wdata
                                                          : mcycleh + mcycle_inc[32];
      minstret  <= (csr_w_en && csr_addr == `CSR_MINSTRET) ? csr_wdata
                                                           : minstret_inc[31:0];
      minstreth <= (csr_w_en && csr_addr == `CSR_MINSTRETH) ? csr_wdata
                                                            : minstreth + minstret_inc[32];
    end
  end

  // software writes first, then trap entry, then return
  always_ff @(posedge clk) begin
    if (rst_sync) begin
      mstatus  <= '0;
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else if (csr_w_en) begin
      case (csr_addr)
        `CSR_MSTATUS:  mstatus  <= csr_wdata & `MSTATUS_LIVE_MASK;
        `CSR_MIE:      mie      <= csr_wdata & `MIE_LIVE_MASK;
        `CSR_MTVEC:    mtvec    <= csr_wdata;
        `CSR_MSCRATCH: mscratch <= csr_wdata;
        `CSR_MEPC:     mepc     <= csr_wdata;
        default: ;
      endcase
    end else if (commit.take) begin
      mepc         <= commit.epc;
      mtval        <= commit.tval;
      mcause       <= {commit.intr, commit.cause};
      mstatus.mpie <= mstatus.mie;
      mstatus.mie  <= 1'b0;
    end else if (mret_take) begin
      mstatus.mie  <= mstatus.mpie;
      mstatus.mpie <= 1'b1;
    end
  end

  // combinational read, anything unmapped returns zero
  always_comb begin
    csr_rdata = '0;
    if (csr_r_en) begin
      case (csr_addr)
        `CSR_MSTATUS:    csr_rdata = mstatus;
        `CSR_MIE:        csr_rdata = mie;
        `CSR_MTVEC:      csr_rdata = mtvec;
        `CSR_MSCRATCH:   csr_rdata = mscratch;
        `CSR_MEPC:       csr_rdata = mepc;
        `CSR_MCAUSE:     csr_rdata = mcause;
        `CSR_MTVAL:      csr_rdata = mtval;
        `CSR_MIP:        csr_rdata = mip;
        `CSR_MCYCLE:     csr_rdata = mcycle;
        `CSR_MCYCLEH:    csr_rdata = mcycleh;
        `CSR_MINSTRET:   csr_rdata = minstret;
        `CSR_MINSTRETH:  csr_rdata = minstreth;
        `CSR_MHARTID:    csr_rdata = `HART_ID_VALUE;
        `CSR_MCONFIGPTR: csr_rdata = `CONFIGPTR_VALUE;
        default:         csr_rdata = '0;
      endcase
    end
  end

  // the pipeline keeps CSR writes away from trap entry and return
  no_write_on_trap_a : assert property (
    @(posedge clk) disable iff (rst_sync)
    csr_w_en |-> !(commit.take || mret_take)
  ) else $error("csr_file: CSR write collides with a trap commit or mret");

endmodule

`default_nettype wire

// File: design/irq_prioritizer.sv
// irq_prioritizer: registered pick of the highest-priority enabled machine interrupt
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

module irq_prioritizer (
  input  logic               clk,
  input  logic               rst_sync,
  input  trap_pkg::mstatus_t mstatus,
  input  trap_pkg::mie_t     mie,
  input  trap_pkg::mip_t     mip,
  output logic               irq_pending,
  output logic [3:0]         irq_code
);

  logic mei_hit;
  logic msi_hit;
  logic mti_hit;

  // line high, locally enabled, and global enable set
  assign mei_hit = mstatus.mie && mie.meie && mip.meie;
  assign msi_hit = mstatus.mie && mie.msie && mip.msie;
  assign mti_hit = mstatus.mie && mie.mtie && mip.mtie;

  // external beats software beats timer
  always_ff @(posedge clk) begin
    if (rst_sync) begin
      irq_pending <= 1'b0;
      irq_code    <= '0;
    end else begin
      irq_pending <= mei_hit || msi_hit || mti_hit;
      if (mei_hit) begin
        irq_code <= `IRQ_CODE_MEI;
      end else if (msi_hit) begin
        irq_code <= `IRQ_CODE_MSI;
      end else begin
        irq_code <= `IRQ_CODE_MTI;
      end
    end
  end

  legal_code_a : assert property (
    @(posedge clk) disable iff (rst_sync)
    irq_pending |-> irq_code inside {`IRQ_CODE_MEI, `IRQ_CODE_MSI, `IRQ_CODE_MTI}
  ) else $error("irq_prioritizer: pending with illegal code %0d", irq_code);

endmodule

`default_nettype wire

// File: design/trap_sequencer.sv
// trap_sequencer: exception/mret/interrupt arbitration, trap commit and redirect
`timescale 1ns/1ps
`default_nettype none

module trap_sequencer (
  input  logic                   clk,
  input  logic                   rst_sync,

  input  logic                   exc_valid,
  output logic                   exc_ready,
  input  trap_pkg::exc_req_t     exc_req,

  input  logic                   irq_pending,
  input  logic [3:0]             irq_code,
  input  logic                   mret,

  input  logic [31:0]            mtvec,
  input  logic [31:0]            mepc,

  output trap_pkg::trap_commit_t commit,
  output logic                   mret_take,

  output logic                   redir_valid,
  input  logic                   redir_ready,
  output trap_pkg::redirect_t    redir
);

  logic mret_pend_q;
  logic irq_hold_q;
  logic mret_req;
  logic take_exc;
  logic take_mret;
  logic take_irq;

  // an mret strobe that loses arbitration waits here
  assign mret_req = mret || mret_pend_q;

  // one decision per cycle, only when the redirect slice has room
  assign take_exc  = exc_valid && redir_ready;
  assign take_mret = mret_req && !exc_valid && redir_ready;
  assign take_irq  = irq_pending && !irq_hold_q && !exc_valid && !mret_req && redir_ready;

  assign exc_ready   = redir_ready;
  assign mret_take   = take_mret;
  assign redir_valid = take_exc || take_mret || take_irq;

  always_comb begin
    commit      = '0;
    commit.take = take_exc || take_irq;
    commit.intr = take_irq;
    if (take_exc) begin
      commit.cause = {27'd0, exc_req.cause};
      commit.epc   = exc_req.pc;
      commit.tval  = exc_req.tval;
    end else if (take_irq) begin
      // no pc on this interface for interrupts, mepc keeps its value
      commit.cause = {27'd0, irq_code};
      commit.epc   = mepc;
    end
  end

  always_comb begin
    redir.pc      = take_mret ? mepc : mtvec;
    redir.is_mret = take_mret;
  end

  // irq_pending lags mstatus by a cycle, so mask it right after a decision
  always_ff @(posedge clk) begin
    if (rst_sync) begin
      mret_pend_q <= 1'b0;
      irq_hold_q  <= 1'b0;
    end else begin
      mret_pend_q <= mret_req && !take_mret;
      irq_hold_q  <= redir_valid;
    end
  end

  one_event_a : assert property (
    @(posedge clk) disable iff (rst_sync)
    !(commit.take && mret_take)
  ) else $error("trap_sequencer: trap commit and mret in the same cycle");

endmodule

`default_nettype wire

// File: design/machine_trap_unit.sv
// machine_trap_unit: top level wiring of slices, prioritizer, sequencer and CSR file
`timescale 1ns/1ps
`default_nettype none

module machine_trap_unit (
  input  logic                clk,
  input  logic                rst_sync,

  input  logic                csr_r_en,
  input  logic                csr_w_en,
  input  logic [11:0]         csr_addr,
  input  logic [31:0]         csr_wdata,
  output logic [31:0]         csr_rdata,

  input  logic                instruction_retire,
  input  logic                mext_int,
  input  logic                msw_int,
  input  logic                mtimer_int,
  input  logic                mret,

  input  logic                exc_valid,
  output logic                exc_ready,
  input  trap_pkg::exc_req_t  exc_req,

  output logic                redir_valid,
  input  logic                redir_ready,
  output trap_pkg::redirect_t redir
);

  logic                   exc_q_valid;
  logic                   exc_q_ready;
  trap_pkg::exc_req_t     exc_q;
  logic                   seq_redir_valid;
  logic                   seq_redir_ready;
  trap_pkg::redirect_t    seq_redir;
  logic                   irq_pending;
  logic [3:0]             irq_code;
  trap_pkg::mstatus_t     mstatus;
  trap_pkg::mie_t         mie;
  trap_pkg::mip_t         mip;
  logic [31:0]            mtvec;
  logic [31:0]            mepc;
  trap_pkg::trap_commit_t commit;
  logic                   mret_take;

  handshake_slice #(.payload_t(trap_pkg::exc_req_t)) exc_slice_inst (
    .clk(clk), .rst_sync(rst_sync),
    .in_valid(exc_valid), .in_ready(exc_ready), .in_data(exc_req),
    .out_valid(exc_q_valid), .out_ready(exc_q_ready), .out_data(exc_q)
  );

  irq_prioritizer irq_prioritizer_inst (
    .clk(clk), .rst_sync(rst_sync), .mstatus(mstatus), .mie(mie), .mip(mip),
    .irq_pending(irq_pending), .irq_code(irq_code)
  );

  trap_sequencer trap_sequencer_inst (
    .clk(clk), .rst_sync(rst_sync),
    .exc_valid(exc_q_valid), .exc_ready(exc_q_ready), .exc_req(exc_q),
    .irq_pending(irq_pending), .irq_code(irq_code), .mret(mret),
    .mtvec(mtvec), .mepc(mepc), .commit(commit), .mret_take(mret_take),
    .redir_valid(seq_redir_valid), .redir_ready(seq_redir_ready), .redir(seq_redir)
  );

  handshake_slice #(.payload_t(trap_pkg::redirect_t)) redir_slice_inst (
    .clk(clk), .rst_sync(rst_sync),
    .in_valid(seq_redir_valid), .in_ready(seq_redir_ready), .in_data(seq_redir),
    .out_valid(redir_valid), .out_ready(redir_ready), .out_data(redir)
  );

  csr_file csr_file_inst (
    .clk(clk), .rst_sync(rst_sync), .instruction_retire(instruction_retire),
    .csr_r_en(csr_r_en), .csr_w_en(csr_w_en), .csr_addr(csr_addr),
    .csr_wdata(csr_wdata), .csr_rdata(csr_rdata),
    .commit(commit), .mret_take(mret_take),
    .mstatus(mstatus), .mie(mie), .mip(mip), .mtvec(mtvec), .mepc(mepc),
    .mext_int(mext_int), .msw_int(msw_int), .mtimer_int(mtimer_int)
  );

endmodule

`default_nettype wire

// File: bench/tb_machine_trap_unit.sv
// clock, reset, seeded stimulus, reference state and checking assertions for the trap unit
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

module tb_machine_trap_unit;

  logic clk;
  logic rst_sync;
  logic csr_r_en;
  logic csr_w_en;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;
  logic instruction_retire;
  logic mext_int;
  logic msw_int;
  logic mtimer_int;
  logic mret;
  logic exc_valid;
  logic exc_ready;
  trap_pkg::exc_req_t exc_req;
  logic redir_valid;
  logic redir_ready;
  trap_pkg::redirect_t redir;

  // reference state kept from the trap and counter rules
  logic [31:0] ref_mtvec;
  logic [31:0] ref_mepc;
  logic [63:0] ref_cycle;
  logic [63:0] ref_instret;
  logic [31:0] exp_rd;
  logic [31:0] exp_now;
  logic rd_chk;
  logic fast_chk;
  logic quiet_win;
  int redir_cnt;
  int errors;

  // inputs as the DUT sees them at the coming edge
  logic s_rst;
  logic s_w;
  logic [11:0] s_addr;
  logic [31:0] s_wdata;
  logic s_ret;

  machine_trap_unit machine_trap_unit_inst (
    .clk(clk), .rst_sync(rst_sync),
    .csr_r_en(csr_r_en), .csr_w_en(csr_w_en), .csr_addr(csr_addr),
    .csr_wdata(csr_wdata), .csr_rdata(csr_rdata),
    .instruction_retire(instruction_retire), .mext_int(mext_int), .msw_int(msw_int),
    .mtimer_int(mtimer_int), .mret(mret),
    .exc_valid(exc_valid), .exc_ready(exc_ready), .exc_req(exc_req),
    .redir_valid(redir_valid), .redir_ready(redir_ready), .redir(redir)
  );

  always #2 clk = ~clk;

  task automatic report_error(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic report_stuck(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  always @(negedge clk) begin
    s_rst   = rst_sync;
    s_w     = csr_w_en;
    s_addr  = csr_addr;
    s_wdata = csr_wdata;
    s_ret   = instruction_retire;
    if (redir_valid && redir_ready) begin
      redir_cnt++;
    end
  end

  // 64-bit counter model where a write replaces the incremented half
  always @(posedge clk) begin
    if (s_rst) begin
      ref_cycle   = '0;
      ref_instret = '0;
    end else begin
      ref_cycle   = ref_cycle + 64'd1;
      ref_instret = ref_instret + {63'd0, s_ret};
      if (s_w) begin
        case (s_addr)
          `CSR_MCYCLE:    ref_cycle[31:0]    = s_wdata;
          `CSR_MCYCLEH:   ref_cycle[63:32]   = s_wdata;
          `CSR_MINSTRET:  ref_instret[31:0]  = s_wdata;
          `CSR_MINSTRETH: ref_instret[63:32] = s_wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (csr_addr)
      `CSR_MCYCLE:    exp_now = ref_cycle[31:0];
      `CSR_MCYCLEH:   exp_now = ref_cycle[63:32];
      `CSR_MINSTRET:  exp_now = ref_instret[31:0];
      `CSR_MINSTRETH: exp_now = ref_instret[63:32];
      default:        exp_now = exp_rd;
    endcase
  end

  read_a : assert property (@(posedge clk) disable iff (rst_sync)
    rd_chk |-> csr_rdata == exp_now)
    else report_error($sformatf("read of %h gave %h, expected %h", csr_addr, csr_rdata, exp_now));

  redir_pc_a : assert property (@(posedge clk) disable iff (rst_sync)
    redir_valid |-> redir.pc == (redir.is_mret ? ref_mepc : ref_mtvec))
    else report_error($sformatf("redirect pc %h is wrong", redir.pc));

  exc_latency_a : assert property (@(posedge clk) disable iff (rst_sync)
    fast_chk && exc_valid && exc_ready |-> ##2 redir_valid && !redir.is_mret)
    else report_error("exception redirect did not arrive two cycles after transfer");

  redir_hold_a : assert property (@(posedge clk) disable iff (rst_sync)
    redir_valid && !redir_ready |=> redir_valid && $stable(redir))
    else report_error("redirect changed while stalled");

  quiet_a : assert property (@(posedge clk) disable iff (rst_sync)
    quiet_win |-> !redir_valid)
    else report_error("interrupt taken while mstatus.mie is clear");

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    @(posedge clk);
    csr_w_en  <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_w_en  <= 1'b0;
  endtask

  task automatic csr_read(input logic [11:0] addr, input logic [31:0] exp);
    @(posedge clk);
    csr_r_en <= 1'b1;
    csr_addr <= addr;
    exp_rd   <= exp;
    rd_chk   <= 1'b1;
    @(posedge clk);
    csr_r_en <= 1'b0;
    rd_chk   <= 1'b0;
  endtask

  task automatic send_exc(input trap_pkg::exc_req_t req);
    int n;
    @(posedge clk);
    exc_valid <= 1'b1;
    exc_req   <= req;
    n = 0;
    forever begin
      @(negedge clk);
      if (exc_ready) break;
      n++;
      if (n > 200) report_stuck("timeout: exception request was never accepted");
    end
    @(posedge clk);
    exc_valid <= 1'b0;
  endtask

  // waits for a redirect and lets it transfer with redir_ready high
  task automatic wait_redir(input logic is_ret);
    int n;
    n = 0;
    forever begin
      @(negedge clk);
      if (redir_valid) break;
      n++;
      if (n > 200) report_stuck("timeout: no redirect from the trap unit");
    end
    if (redir.is_mret != is_ret) report_error("redirect has the wrong mret flag");
    @(posedge clk);
  endtask

  function automatic trap_pkg::exc_req_t rand_exc();
    trap_pkg::exc_req_t r;
    r.cause = 4'($urandom);
    r.pc    = $urandom & 32'hFFFF_FFFC;
    r.tval  = $urandom;
    return r;
  endfunction

  initial begin
    trap_pkg::exc_req_t ea;
    trap_pkg::exc_req_t eb;
    int base;
    int n;
    logic [31:0] v;
    void'($urandom(20871));
    clk = 1'b0;
    errors = 0;
    redir_cnt = 0;
    s_rst = 1'b1;
    rst_sync <= 1'b1;
    csr_r_en <= 1'b0;
    csr_w_en <= 1'b0;
    csr_addr <= '0;
    csr_wdata <= '0;
    instruction_retire <= 1'b0;
    mext_int <= 1'b0;
    msw_int <= 1'b0;
    mtimer_int <= 1'b0;
    mret <= 1'b0;
    exc_valid <= 1'b0;
    exc_req <= '0;
    redir_ready <= 1'b1;
    ref_mtvec <= '0;
    ref_mepc <= '0;
    exp_rd <= '0;
    rd_chk <= 1'b0;
    fast_chk <= 1'b0;
    quiet_win <= 1'b0;
    repeat (5) @(posedge clk);
    rst_sync <= 1'b0;

    // CSR port, live bits and read-only registers
    v = $urandom;
    csr_write(`CSR_MSCRATCH, v);
    csr_read(`CSR_MSCRATCH, v);
    csr_write(`CSR_MSTATUS, 32'hFFFF_FFFF);
    csr_read(`CSR_MSTATUS, 32'h88);
    csr_write(`CSR_MSTATUS, 32'h0);
    csr_write(`CSR_MIE, 32'hFFFF_FFFF);
    csr_read(`CSR_MIE, 32'h888);
    csr_write(`CSR_MIE, 32'h0);
    csr_write(`CSR_MCAUSE, 32'h1234);
    csr_read(`CSR_MCAUSE, 32'h0);
    csr_write(`CSR_MTVAL, 32'h5678);
    csr_read(`CSR_MTVAL, 32'h0);
    csr_write(`CSR_MIP, 32'h888);
    csr_read(`CSR_MIP, 32'h0);
    csr_write(`CSR_MHARTID, 32'h1);
    csr_read(`CSR_MHARTID, 32'h0);
    csr_write(`CSR_MCONFIGPTR, 32'h1);
    csr_read(`CSR_MCONFIGPTR, 32'h0);
    csr_read(12'h7C0, 32'h0);

    // counters with random retire pulses and carries into the high halves
    csr_read(`CSR_MCYCLE, 32'h0);
    repeat (30) begin
      @(posedge clk);
      instruction_retire <= 1'($urandom);
    end
    @(posedge clk);
    instruction_retire <= 1'b0;
    csr_read(`CSR_MCYCLE, 32'h0);
    csr_read(`CSR_MINSTRET, 32'h0);
    csr_write(`CSR_MCYCLEH, 32'h5);
    csr_write(`CSR_MCYCLE, 32'hFFFF_FFF0);
    csr_write(`CSR_MINSTRET, 32'hFFFF_FFFF);
    repeat (3) begin
      @(posedge clk);
      instruction_retire <= 1'b1;
    end
    @(posedge clk);
    instruction_retire <= 1'b0;
    repeat (16) @(posedge clk);
    csr_read(`CSR_MCYCLEH, 32'h0);
    csr_read(`CSR_MINSTRETH, 32'h0);
    csr_read(`CSR_MINSTRET, 32'h0);

    // exception trap with mie set
    v = $urandom & 32'hFFFF_FFFC;
    ref_mtvec <= v;
    csr_write(`CSR_MTVEC, v);
    csr_write(`CSR_MSTATUS, 32'h8);
    ea = rand_exc();
    ref_mepc <= ea.pc;
    fast_chk <= 1'b1;
    send_exc(ea);
    wait_redir(1'b0);
    fast_chk <= 1'b0;
    csr_read(`CSR_MEPC, ea.pc);
    csr_read(`CSR_MCAUSE, {28'd0, ea.cause});
    csr_read(`CSR_MTVAL, ea.tval);
    csr_read(`CSR_MSTATUS, 32'h80);

    // all lines high and nothing taken while the global enable is clear
    csr_write(`CSR_MIE, 32'h888);
    @(posedge clk);
    mext_int <= 1'b1;
    msw_int <= 1'b1;
    mtimer_int <= 1'b1;
    quiet_win <= 1'b1;
    repeat (20) @(posedge clk);
    quiet_win <= 1'b0;
    csr_write(`CSR_MSTATUS, 32'h8);
    wait_redir(1'b0);
    mext_int <= 1'b0;
    msw_int <= 1'b0;
    mtimer_int <= 1'b0;
    csr_read(`CSR_MCAUSE, 32'h8000_000B);
    csr_read(`CSR_MTVAL, 32'h0);
    csr_read(`CSR_MEPC, ea.pc);
    csr_read(`CSR_MSTATUS, 32'h80);

    // return and then software beats timer
    @(posedge clk);
    mret <= 1'b1;
    @(posedge clk);
    mret <= 1'b0;
    wait_redir(1'b1);
    csr_read(`CSR_MSTATUS, 32'h88);
    @(posedge clk);
    msw_int <= 1'b1;
    mtimer_int <= 1'b1;
    wait_redir(1'b0);
    msw_int <= 1'b0;
    mtimer_int <= 1'b0;
    csr_read(`CSR_MCAUSE, 32'h8000_0003);
    csr_read(`CSR_MSTATUS, 32'h80);

    // two exceptions stored while the core stalls the redirect
    base = redir_cnt;
    @(posedge clk);
    redir_ready <= 1'b0;
    ea = rand_exc();
    eb = rand_exc();
    send_exc(ea);
    send_exc(eb);
    @(negedge clk);
    if (exc_ready) report_error("exc_ready stayed high with both slices full");
    repeat (8) @(posedge clk);
    n = 0;
    while (redir_cnt < base + 2) begin
      @(posedge clk);
      redir_ready <= 1'($urandom);
      n++;
      if (n > 300) report_stuck("timeout: stalled redirects never drained");
    end
    redir_ready <= 1'b1;
    repeat (10) @(posedge clk);
    if (redir_cnt != base + 2) report_error("redirect count wrong after back-pressure");
    csr_read(`CSR_MEPC, eb.pc);
    csr_read(`CSR_MTVAL, eb.tval);
    repeat (4) @(posedge clk);

    if (errors == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

  initial begin
    #400000;
    report_stuck("timeout: simulation ran past its time limit");
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/trap_pkg.sv
design/handshake_slice.sv
design/csr_file.sv
design/irq_prioritizer.sv
design/trap_sequencer.sv
design/machine_trap_unit.sv
bench/tb_machine_trap_unit.sv
